// ==== src/dram_cache_pkg.sv ====
`default_nettype none

package dram_cache_pkg;

	// processor side AXI address channels
	localparam int ADDR_WIDTH = 32;
	localparam int ID_WIDTH = 4;

	// every metadata read carries this id so responses come back in order
	localparam logic [ID_WIDTH-1:0] META_ID = 4'hA;

	// address split: | tag | index | offset |
	localparam int OFFSET_WIDTH = 6;
	localparam int INDEX_WIDTH = 10;
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	localparam int TID_WIDTH = 8;

	// tag FIFO sizing
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_WIDTH = FIFO_PTR_WIDTH + 1;
	// two below full leaves room for a push already on its way
	localparam int FIFO_AFULL_LEVEL = FIFO_DEPTH - 2;

	// one entry per accepted processor request
	typedef struct packed {
		logic is_write;
		logic [TID_WIDTH-1:0] tid;
		logic [ADDR_WIDTH-1:0] addr;
	} req_record_t;

	// metadata word returned by the tag memory
	typedef struct packed {
		logic valid;
		logic [TAG_WIDTH-1:0] tag;
	} meta_t;

endpackage

`default_nettype wire

// ==== src/index_extractor.sv ====
`default_nettype none

module index_extractor
	import dram_cache_pkg::*;
(
	input wire clk,
	input wire rst_n,

	// processor read address
	input wire [ID_WIDTH-1:0] arid_i,
	input wire [ADDR_WIDTH-1:0] araddr_i,
	input wire arvalid_i,
	output logic arready_o,

	// processor write address
	input wire [ID_WIDTH-1:0] awid_i,
	input wire [ADDR_WIDTH-1:0] awaddr_i,
	input wire awvalid_i,
	output logic awready_o,

	// metadata read towards the tag memory
	output logic [ID_WIDTH-1:0] mar_id_o,
	output logic [ADDR_WIDTH-1:0] mar_addr_o,
	output logic mar_valid_o,
	input wire mar_ready_i,

	// tag FIFO push side
	input wire afull_i,
	output logic push_o,
	output req_record_t record_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_REQ,
		S_RD_PUSH,
		S_WR_REQ,
		S_WR_PUSH
	} state_t;

	state_t state, state_n;
	logic arbiter, arbiter_n;
	logic [TID_WIDTH-1:0] tid, tid_n;
	logic ready, ready_n;
	logic mar_valid, mar_valid_n;
	logic push, push_n;
	logic [ADDR_WIDTH-1:0] mar_addr, mar_addr_n;
	req_record_t record, record_n;
	logic rd_accept;
	logic wr_accept;

	// keep only the set index, offset and tag go to zero
	function automatic logic [ADDR_WIDTH-1:0] set_address(input logic [ADDR_WIDTH-1:0] addr);
		logic [ADDR_WIDTH-1:0] result;
		result = '0;
		result[OFFSET_WIDTH +: INDEX_WIDTH] = addr[OFFSET_WIDTH +: INDEX_WIDTH];
		return result;
	endfunction

	// arbiter low gives read the priority, high gives write
	// both readys are high in idle, only the granted channel is taken
	assign rd_accept = (state == S_IDLE) && ready && arvalid_i && (!awvalid_i || !arbiter);
	assign wr_accept = (state == S_IDLE) && ready && awvalid_i && (!arvalid_i || arbiter);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			arbiter <= 1'b0;
			tid <= TID_WIDTH'(1);
			ready <= 1'b1;
			mar_valid <= 1'b0;
			push <= 1'b0;
		end else begin
			state <= state_n;
			arbiter <= arbiter_n;
			tid <= tid_n;
			ready <= ready_n;
			mar_valid <= mar_valid_n;
			push <= push_n;
		end
	end

	always_ff @(posedge clk) begin
		mar_addr <= mar_addr_n;
		record <= record_n;
	end

	always_comb begin
		state_n = state;
		arbiter_n = arbiter;
		tid_n = tid;
		ready_n = ready;
		mar_valid_n = mar_valid;
		push_n = 1'b0;
		mar_addr_n = mar_addr;
		record_n = record;

		case (state)
			S_IDLE: begin
				ready_n = !afull_i;
				if (rd_accept) begin
					mar_addr_n = set_address(araddr_i);
					record_n.is_write = 1'b0;
					record_n.tid = tid;
					record_n.addr = araddr_i;
					tid_n = tid + 1'b1;
					arbiter_n = 1'b1;
					ready_n = 1'b0;
					mar_valid_n = 1'b1;
					state_n = S_RD_REQ;
				end else if (wr_accept) begin
					mar_addr_n = set_address(awaddr_i);
					record_n.is_write = 1'b1;
					record_n.tid = '0;
					record_n.addr = awaddr_i;
					arbiter_n = 1'b0;
					ready_n = 1'b0;
					mar_valid_n = 1'b1;
					state_n = S_WR_REQ;
				end
			end
			S_RD_REQ, S_WR_REQ: begin
				if (mar_ready_i) begin
					mar_valid_n = 1'b0;
					push_n = 1'b1;
					state_n = (state == S_RD_REQ) ? S_RD_PUSH : S_WR_PUSH;
				end
			end
			S_RD_PUSH, S_WR_PUSH: begin
				// afull still shows the level before this push
				ready_n = !afull_i;
				state_n = S_IDLE;
			end
			default: begin
				state_n = S_IDLE;
			end
		endcase
	end

	assign arready_o = ready;
	assign awready_o = ready;
	assign mar_id_o = META_ID;
	assign mar_addr_o = mar_addr;
	assign mar_valid_o = mar_valid;
	assign push_o = push;
	assign record_o = record;

	// metadata request must not change while it waits for the tag memory
	assert property (@(posedge clk) disable iff (!rst_n)
		mar_valid_o && !mar_ready_i |=> mar_valid_o && $stable(mar_addr_o));

	// a processor request that is not taken yet keeps its payload
	assert property (@(posedge clk) disable iff (!rst_n)
		arvalid_i && !rd_accept |=> arvalid_i && $stable(araddr_i) && $stable(arid_i));

	assert property (@(posedge clk) disable iff (!rst_n)
		awvalid_i && !wr_accept |=> awvalid_i && $stable(awaddr_i) && $stable(awid_i));

endmodule

`default_nettype wire

// ==== src/tag_fifo.sv ====
`default_nettype none

module tag_fifo
	import dram_cache_pkg::*;
#(
	parameter type payload_t = req_record_t
)
(
	input wire clk,
	input wire rst_n,

	input wire push_i,
	input wire payload_t data_i,

	input wire pop_i,
	output payload_t head_o,

	output logic empty_o,
	output logic afull_o
);

	payload_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
	logic [FIFO_CNT_WIDTH-1:0] count;

	// payload storage
	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr] <= data_i;
		end
	end

	// depth is a power of two so the pointers wrap by themselves
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_o = mem[rd_ptr];
	assign empty_o = (count == '0);
	assign afull_o = (count >= FIFO_CNT_WIDTH'(FIFO_AFULL_LEVEL));

	// the almost-full margin must keep the writer from overrunning
	assert property (@(posedge clk) disable iff (!rst_n)
		push_i |-> count != FIFO_CNT_WIDTH'(FIFO_DEPTH));

	assert property (@(posedge clk) disable iff (!rst_n)
		pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== src/tag_comparator.sv ====
`default_nettype none

module tag_comparator
	import dram_cache_pkg::*;
(
	input wire clk,
	input wire rst_n,

	// metadata response from the tag memory
	input wire meta_t mr_data_i,
	input wire mr_valid_i,
	output logic mr_ready_o,

	// tag FIFO pop side
	input wire req_record_t head_i,
	input wire empty_i,
	output logic pop_o,

	// lookup result
	output logic res_valid_o,
	output logic res_hit_o,
	output logic res_write_o,
	output logic [TID_WIDTH-1:0] res_tid_o,
	output logic [ADDR_WIDTH-1:0] res_addr_o,
	input wire res_ready_i
);

	logic res_valid;
	logic res_hit;
	logic res_write;
	logic [TID_WIDTH-1:0] res_tid;
	logic [ADDR_WIDTH-1:0] res_addr;

	logic [TAG_WIDTH-1:0] head_tag;
	logic slot_free;
	logic r_fire;
	logic hit;

	assign head_tag = head_i.addr[OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];

	// result register empty now or emptied at this edge
	assign slot_free = !res_valid || res_ready_i;

	// responses are in order, so the FIFO head is always the matching request
	assign mr_ready_o = !empty_i && slot_free;
	assign r_fire = mr_valid_i && mr_ready_o;
	assign pop_o = r_fire;

	assign hit = mr_data_i.valid && (mr_data_i.tag == head_tag);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (r_fire) begin
			res_valid <= 1'b1;
		end else if (res_ready_i) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (r_fire) begin
			res_hit <= hit;
			res_write <= head_i.is_write;
			res_tid <= head_i.tid;
			res_addr <= head_i.addr;
		end
	end

	assign res_valid_o = res_valid;
	assign res_hit_o = res_hit;
	assign res_write_o = res_write;
	assign res_tid_o = res_tid;
	assign res_addr_o = res_addr;

	// a stalled result keeps all of its fields
	assert property (@(posedge clk) disable iff (!rst_n)
		res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_hit_o)
			&& $stable(res_write_o) && $stable(res_tid_o) && $stable(res_addr_o));

endmodule

`default_nettype wire

// ==== src/dram_cache_lookup.sv ====
`default_nettype none

module dram_cache_lookup
	import dram_cache_pkg::*;
(
	input wire clk,
	input wire rst_n,

	// processor read address
	input wire [ID_WIDTH-1:0] arid_i,
	input wire [ADDR_WIDTH-1:0] araddr_i,
	input wire arvalid_i,
	output logic arready_o,

	// processor write address
	input wire [ID_WIDTH-1:0] awid_i,
	input wire [ADDR_WIDTH-1:0] awaddr_i,
	input wire awvalid_i,
	output logic awready_o,

	// tag memory read address
	output logic [ID_WIDTH-1:0] mar_id_o,
	output logic [ADDR_WIDTH-1:0] mar_addr_o,
	output logic mar_valid_o,
	input wire mar_ready_i,

	// tag memory read data
	input wire meta_t mr_data_i,
	input wire mr_valid_i,
	output logic mr_ready_o,

	// lookup result
	output logic res_valid_o,
	output logic res_hit_o,
	output logic res_write_o,
	output logic [TID_WIDTH-1:0] res_tid_o,
	output logic [ADDR_WIDTH-1:0] res_addr_o,
	input wire res_ready_i
);

	logic fifo_push;
	req_record_t fifo_data;
	logic fifo_afull;
	logic fifo_pop;
	req_record_t fifo_head;
	logic fifo_empty;

	index_extractor u_index_extractor (
		.clk(clk),
		.rst_n(rst_n),
		.arid_i(arid_i),
		.araddr_i(araddr_i),
		.arvalid_i(arvalid_i),
		.arready_o(arready_o),
		.awid_i(awid_i),
		.awaddr_i(awaddr_i),
		.awvalid_i(awvalid_i),
		.awready_o(awready_o),
		.mar_id_o(mar_id_o),
		.mar_addr_o(mar_addr_o),
		.mar_valid_o(mar_valid_o),
		.mar_ready_i(mar_ready_i),
		.afull_i(fifo_afull),
		.push_o(fifo_push),
		.record_o(fifo_data)
	);

	tag_fifo #(
		.payload_t(req_record_t)
	) u_tag_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push_i(fifo_push),
		.data_i(fifo_data),
		.pop_i(fifo_pop),
		.head_o(fifo_head),
		.empty_o(fifo_empty),
		.afull_o(fifo_afull)
	);

	tag_comparator u_tag_comparator (
		.clk(clk),
		.rst_n(rst_n),
		.mr_data_i(mr_data_i),
		.mr_valid_i(mr_valid_i),
		.mr_ready_o(mr_ready_o),
		.head_i(fifo_head),
		.empty_i(fifo_empty),
		.pop_o(fifo_pop),
		.res_valid_o(res_valid_o),
		.res_hit_o(res_hit_o),
		.res_write_o(res_write_o),
		.res_tid_o(res_tid_o),
		.res_addr_o(res_addr_o),
		.res_ready_i(res_ready_i)
	);

endmodule

`default_nettype wire

// ==== verification/tb_dram_cache_lookup.sv ====
`default_nettype none

module tb_dram_cache_lookup
	import dram_cache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 400;

	typedef struct packed {
		req_record_t rec;
		logic hit;
	} expect_t;

	typedef struct packed {
		meta_t data;
		logic [31:0] due;
	} resp_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [ID_WIDTH-1:0] arid_i, awid_i, mar_id_o;
	logic [ADDR_WIDTH-1:0] araddr_i, awaddr_i, mar_addr_o, res_addr_o;
	logic arvalid_i, arready_o, awvalid_i, awready_o, mar_valid_o, mar_ready_i;
	logic mr_valid_i, mr_ready_o, res_valid_o, res_hit_o, res_write_o, res_ready_i;
	logic [TID_WIDTH-1:0] res_tid_o;
	meta_t mr_data_i;

	meta_t meta_mem [2**INDEX_WIDTH];
	expect_t exp_q [$];
	resp_t resp_q [$];
	logic [ADDR_WIDTH-1:0] mar_exp_q [$];
	logic [8:0] result_log [$];
	logic [7:0] lfsr = 8'd95;
	logic [31:0] cycle = 0;
	logic [TID_WIDTH-1:0] next_tid;
	logic wr_turn;
	logic snap_mar_valid;
	logic snap_mr_ready;
	logic [ADDR_WIDTH-1:0] snap_mar_addr;
	logic [ADDR_WIDTH-1:0] last_mar_addr;
	logic [41:0] last_result;
	int checks = 0;
	int errors = 0;
	int rd_accepts = 0;
	int wr_accepts = 0;
	int results = 0;

	always #50 clk = ~clk;

	dram_cache_lookup i_dut (.*);

	// taps 8, 6, 5, 4
	function automatic logic next_random_bit();
		logic feedback;
		feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
		lfsr = {lfsr[6:0], feedback};
		return feedback;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], next_random_bit()};
		end
		return value;
	endfunction

	function automatic logic expect_hit(input logic [ADDR_WIDTH-1:0] addr);
		meta_t m;
		m = meta_mem[addr[OFFSET_WIDTH +: INDEX_WIDTH]];
		return m.valid && (m.tag == addr[ADDR_WIDTH-1 -: TAG_WIDTH]);
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#5;
	endtask

	// snapshots at the falling edge, where inputs and outputs are settled
	always @(negedge clk) begin
		expect_t entry;
		logic taken;
		taken = 1'b0;
		snap_mar_valid = mar_valid_o;
		snap_mar_addr = mar_addr_o;
		snap_mr_ready = mr_ready_o;
		if (!rst_n) begin
			next_tid = 1;
			wr_turn = 1'b0;
		end else begin
			if (mar_valid_o) begin
				check_value(mar_id_o, META_ID, "metadata read id");
			end
			// alternating grant, read first after reset
			if (arready_o && arvalid_i && (!awvalid_i || !wr_turn)) begin
				entry = {1'b0, next_tid, araddr_i, expect_hit(araddr_i)};
				next_tid++;
				wr_turn = 1'b1;
				rd_accepts++;
				taken = 1'b1;
			end else if (awready_o && awvalid_i && (!arvalid_i || wr_turn)) begin
				entry = {1'b1, TID_WIDTH'(0), awaddr_i, expect_hit(awaddr_i)};
				wr_turn = 1'b0;
				wr_accepts++;
				taken = 1'b1;
			end
			if (taken) begin
				exp_q.push_back(entry);
				mar_exp_q.push_back({{TAG_WIDTH{1'b0}},
					entry.rec.addr[OFFSET_WIDTH +: INDEX_WIDTH], {OFFSET_WIDTH{1'b0}}});
			end
			if (res_valid_o && res_ready_i) begin
				last_result = {res_hit_o, res_write_o, res_tid_o, res_addr_o};
				result_log.push_back({res_write_o, res_tid_o});
				results++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("result at %0t ns with no request outstanding", $time);
				end else begin
					entry = exp_q.pop_front();
					check_value(last_result, {entry.hit, entry.rec}, "result against model");
				end
			end
		end
	end

	// behavioral tag memory, answers in order after two to five cycles
	always @(posedge clk) begin
		resp_t resp;
		#5;
		cycle++;
		if (!rst_n) begin
			mar_ready_i = 1'b0;
			mr_valid_i = 1'b0;
			resp_q.delete();
		end else begin
			if (mr_valid_i && snap_mr_ready) begin
				void'(resp_q.pop_front());
			end
			if (snap_mar_valid && mar_ready_i) begin
				last_mar_addr = snap_mar_addr;
				if (mar_exp_q.size() == 0) begin
					errors++;
					$display("metadata read at %0t ns with no request outstanding", $time);
				end else begin
					check_value(snap_mar_addr, mar_exp_q.pop_front(), "metadata read address");
				end
				resp.data = meta_mem[snap_mar_addr[OFFSET_WIDTH +: INDEX_WIDTH]];
				resp.due = cycle + 2 + random_bits(2);
				resp_q.push_back(resp);
			end
			mar_ready_i = next_random_bit();
			mr_valid_i = (resp_q.size() > 0) && (resp_q[0].due <= cycle);
			if (mr_valid_i) begin
				mr_data_i = resp_q[0].data;
			end else begin
				mr_data_i = '0;
			end
		end
	end

	task automatic send_request(input logic is_write, input logic [ADDR_WIDTH-1:0] addr);
		int start;
		int waited;
		start = is_write ? wr_accepts : rd_accepts;
		waited = 0;
		if (is_write) begin
			awvalid_i = 1'b1;
			awaddr_i = addr;
		end else begin
			arvalid_i = 1'b1;
			araddr_i = addr;
		end
		do begin
			step_cycle();
			waited++;
		end while ((is_write ? wr_accepts : rd_accepts) == start && waited < WAIT_LIMIT);
		if ((is_write ? wr_accepts : rd_accepts) == start) begin
			report_timeout("address acceptance");
		end
		if (is_write) begin
			awvalid_i = 1'b0;
		end else begin
			arvalid_i = 1'b0;
		end
	endtask

	task automatic wait_results(input int target, input string what);
		int waited;
		waited = 0;
		while (results < target && waited < WAIT_LIMIT) begin
			step_cycle();
			waited++;
		end
		if (results < target) begin
			report_timeout(what);
		end
	endtask

	task automatic read_miss_test();
		logic [ADDR_WIDTH-1:0] addr;
		int base;
		addr = 32'h1234_5A44;
		base = results;
		send_request(1'b0, addr);
		wait_results(base + 1, "read miss result");
		check_value(last_result, {1'b0, 1'b0, 8'd1, addr}, "read miss result");
		check_value(last_mar_addr, {16'h0, addr[15:6], 6'h0}, "metadata address of read");
	endtask

	task automatic read_hit_test();
		logic [ADDR_WIDTH-1:0] addr;
		int base;
		addr = 32'hABCD_1380;
		meta_mem[addr[15:6]] = {1'b1, addr[31:16]};
		base = results;
		send_request(1'b0, addr);
		wait_results(base + 1, "read hit result");
		check_value(last_result, {1'b1, 1'b0, 8'd2, addr}, "read hit result");
		addr[31:16] = 16'h0F0F;
		send_request(1'b0, addr);
		wait_results(base + 2, "read result with other tag");
		check_value(last_result, {1'b0, 1'b0, 8'd3, addr}, "read with other tag");
	endtask

	task automatic write_lookup_test();
		logic [ADDR_WIDTH-1:0] addr;
		int base;
		addr = 32'h4444_0FC0;
		meta_mem[addr[15:6]] = {1'b1, addr[31:16]};
		base = results;
		send_request(1'b1, addr);
		wait_results(base + 1, "write hit result");
		check_value(last_result, {1'b1, 1'b1, 8'd0, addr}, "write hit result");
		check_value(last_mar_addr, {16'h0, addr[15:6], 6'h0}, "metadata address of write");
		addr[31:16] = 16'h4445;
		send_request(1'b1, addr);
		wait_results(base + 2, "write miss result");
		check_value(last_result, {1'b0, 1'b1, 8'd0, addr}, "write miss result");
	endtask

	task automatic arbitration_test();
		int first;
		int base;
		first = result_log.size();
		base = results;
		fork
			for (int i = 0; i < 3; i++) begin
				send_request(1'b0, 32'h0000_2000 + 32'(i * 64));
			end
			for (int i = 0; i < 3; i++) begin
				send_request(1'b1, 32'h0001_3000 + 32'(i * 64));
			end
		join
		wait_results(base + 6, "arbitrated results");
		// three reads went before, so read tids continue at 4
		for (int i = 0; i < 6 && first + i < result_log.size(); i++) begin
			check_value(result_log[first + i][8], i % 2, "read and write alternate");
			check_value(result_log[first + i][7:0], (i % 2) ? 0 : 4 + i / 2, "transaction id");
		end
	endtask

	task automatic backpressure_test();
		logic [ADDR_WIDTH-1:0] addrs [10];
		logic [41:0] held;
		int base;
		int start;
		int waited;
		for (int i = 0; i < 10; i++) begin
			addrs[i] = ADDR_WIDTH'(random_bits(TAG_WIDTH + INDEX_WIDTH)) << OFFSET_WIDTH;
		end
		meta_mem[addrs[3][15:6]] = {1'b1, addrs[3][31:16]};
		base = results;
		start = rd_accepts;
		res_ready_i = 1'b0;
		fork
			for (int i = 0; i < 10; i++) begin
				send_request(1'b0, addrs[i]);
			end
			begin
				waited = 0;
				while (!res_valid_o && waited < WAIT_LIMIT) begin
					step_cycle();
					waited++;
				end
				if (!res_valid_o) begin
					report_timeout("first result under back-pressure");
				end
				held = {res_hit_o, res_write_o, res_tid_o, res_addr_o};
				repeat (10) begin
					step_cycle();
					check_value({res_valid_o, res_hit_o, res_write_o, res_tid_o, res_addr_o},
						{1'b1, held}, "held result");
				end
				// one result held, FIFO stops one push past almost-full
				waited = 0;
				while (rd_accepts - start < FIFO_AFULL_LEVEL + 2 && waited < WAIT_LIMIT) begin
					step_cycle();
					waited++;
				end
				if (rd_accepts - start < FIFO_AFULL_LEVEL + 2) begin
					report_timeout("FIFO fill");
				end
				repeat (20) begin
					step_cycle();
					check_value({arready_o, awready_o}, 2'b00, "processor readys with FIFO full");
				end
				check_value(rd_accepts - start, FIFO_AFULL_LEVEL + 2, "requests taken while stalled");
				res_ready_i = 1'b1;
			end
		join
		wait_results(base + 10, "results after release");
	endtask

	initial begin
		rst_n = 1'b0;
		arid_i = 4'h3;
		araddr_i = '0;
		arvalid_i = 1'b0;
		awid_i = 4'h5;
		awaddr_i = '0;
		awvalid_i = 1'b0;
		mar_ready_i = 1'b0;
		mr_data_i = '0;
		mr_valid_i = 1'b0;
		res_ready_i = 1'b1;
		for (int i = 0; i < 2**INDEX_WIDTH; i++) begin
			meta_mem[i] = {1'b0, TAG_WIDTH'(i * 37)};
		end
		repeat (10) @(posedge clk);
		#5;
		rst_n = 1'b1;
		step_cycle();
		check_value({arready_o, awready_o}, 2'b11, "processor readys after reset");
		read_miss_test();
		read_hit_test();
		write_lookup_test();
		arbitration_test();
		backpressure_test();
		check_value(exp_q.size(), 0, "requests left without a result");
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
src/dram_cache_pkg.sv
src/index_extractor.sv
src/tag_fifo.sv
src/tag_comparator.sv
src/dram_cache_lookup.sv
verification/tb_dram_cache_lookup.sv
